// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sampler_top
FILELIST  = build.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TESTBENCH PASSED

SOURCES = $(filter-out +incdir+%,$(shell cat $(FILELIST))) sampler_consts.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+.
sampler_pkg.sv
capture_unit.sv
sample_fifo.sv
sample_collector.sv
sampler_top.sv
tb_sampler_top.sv

// ==== capture_unit.sv ====
//==============================
// capture unit
// converter front end at a fixed bus position that
// latches its raw input and drives the shared sample bus
//==============================
`default_nettype none

module capture_unit #(
  // bus position this unit answers to, 255 is reserved for empty slots
  parameter logic [7:0] UNIT_POSITION = 8'd1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] raw,
  input  logic [7:0]  channel_select,
  input  logic        output_sample,
  output logic [31:0] sample_data
);

  logic        selected;
  logic        strobe_d;
  logic        strobe_rise;
  logic [15:0] capture_reg;

  // the collector puts the polled position on channel_select
  assign selected = (channel_select == UNIT_POSITION);

  // the strobe stays high for two cycles, only its first cycle is used
  // so the captured value holds still through fetch_wait and store
  assign strobe_rise = output_sample & ~strobe_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_d <= 1'b0;
    end else begin
      strobe_d <= output_sample;
    end
  end

  // raw is taken at the end of fetch when this unit is being polled
  always_ff @(posedge clk) begin
    if (rst) begin
      capture_reg <= '0;
    end else if (strobe_rise && selected) begin
      capture_reg <= raw;
    end
  end

  // the sample bus is an OR of all units
  // so an unselected unit has to drive zero
  assign sample_data = selected ? {16'd0, capture_reg} : 32'd0;

endmodule

`default_nettype wire

// ==== sample_collector.sv ====
//==============================
// sample collector
// keeps a table of capture units written over the command bus,
// polls them in turn and pushes changed samples into the FIFO
//==============================
`default_nettype none
`include "sampler_consts.svh"

module sample_collector (
  input  logic                      clk,
  input  logic                      rst,
  input  sampler_pkg::cmd_bus_t     cmd,
  input  logic [31:0]               sample_data,
  output logic                      output_sample,
  output logic [7:0]                channel_select,
  output logic                      fifo_wr,
  output sampler_pkg::sample_word_t fifo_din,
  output logic                      fifo_clear
);

  localparam int IDX_W = $clog2(`SAMPLER_MAX_UNITS);
  localparam int CNT_W = $clog2(`SAMPLER_MAX_UNITS + 1);

  // one-hot polling states
  localparam logic [4:0] S_IDLE       = 5'b00001;
  localparam logic [4:0] S_FETCH      = 5'b00010;
  localparam logic [4:0] S_FETCH_WAIT = 5'b00100;
  localparam logic [4:0] S_STORE      = 5'b01000;
  localparam logic [4:0] S_INCREMENT  = 5'b10000;

  // unit table holds bus positions, last_value the previous sample per index
  logic [7:0]       unit_table [`SAMPLER_MAX_UNITS];
  logic [31:0]      last_value [`SAMPLER_MAX_UNITS];
  logic [CNT_W-1:0] num_units;
  logic [IDX_W-1:0] poll_idx;
  logic [IDX_W-1:0] last_idx;
  logic             table_full;
  logic [31:0]      command;
  logic [4:0]       state;
  logic [4:0]       next_state;

  logic bus_wr;
  logic new_unit_wr;
  logic new_unit_d;
  logic new_unit_dd;
  logic new_unit_done;
  logic sample_changed;

  // control strobes from the state machine
  logic inc_idx;
  logic clr_cmd;
  logic clr_all;
  logic clr_fifo;

  // a write is ours when the high address byte matches our position
  assign bus_wr      = cmd.cs & cmd.wr & (cmd.addr[15:8] == `SAMPLER_POSITION);
  assign new_unit_wr = bus_wr & (cmd.addr[7:0] == `SAMPLER_ADDR_NEW_UNIT);

  // the registration strobe is delayed twice and its falling edge marks
  // the end of the transfer, which is when the unit count moves on
  always_ff @(posedge clk) begin
    if (rst) begin
      new_unit_d  <= 1'b0;
      new_unit_dd <= 1'b0;
    end else begin
      new_unit_d  <= new_unit_wr;
      new_unit_dd <= new_unit_d;
    end
  end

  assign new_unit_done = new_unit_dd & ~new_unit_d;

  assign table_full = (num_units == CNT_W'(`SAMPLER_MAX_UNITS));
  // highest valid index, the wrap point of the polling index
  // with an empty table this wraps to the top entry, which stays harmless
  assign last_idx = IDX_W'(num_units - CNT_W'(1));

  assign channel_select = unit_table[poll_idx];
  assign sample_changed = (last_value[poll_idx] != sample_data);

  // entry is the table index plus the low 13 bits of the capture word
  assign fifo_din   = '{unit_idx: poll_idx, value: sample_data[12:0]};
  assign fifo_clear = clr_fifo | clr_all;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // every poll runs fetch, fetch_wait, store and increment
  // commands other than start are only looked at in idle and increment
  always_comb begin
    next_state    = state;
    output_sample = 1'b0;
    fifo_wr       = 1'b0;
    inc_idx       = 1'b0;
    clr_cmd       = 1'b0;
    clr_all       = 1'b0;
    clr_fifo      = 1'b0;
    case (state)
      S_IDLE: begin
        if (command == `SAMPLER_CMD_START) begin
          clr_cmd    = 1'b1;
          next_state = S_FETCH;
        end else if (command == `SAMPLER_CMD_RESET) begin
          clr_all = 1'b1;
        end else if (command == `SAMPLER_CMD_RES_FIFO) begin
          clr_fifo = 1'b1;
          clr_cmd  = 1'b1;
        end
      end
      S_FETCH: begin
        // the selected unit latches its input on the first strobe cycle
        output_sample = 1'b1;
        next_state    = S_FETCH_WAIT;
      end
      S_FETCH_WAIT: begin
        // one cycle for the capture register to reach the sample bus
        output_sample = 1'b1;
        next_state    = S_STORE;
      end
      S_STORE: begin
        fifo_wr    = sample_changed;
        next_state = S_INCREMENT;
      end
      S_INCREMENT: begin
        inc_idx    = 1'b1;
        next_state = S_FETCH;
        if (command == `SAMPLER_CMD_RESET) begin
          clr_all    = 1'b1;
          next_state = S_IDLE;
        end else if (command == `SAMPLER_CMD_STOP) begin
          clr_cmd    = 1'b1;
          next_state = S_IDLE;
        end
      end
      default: begin
        next_state = S_IDLE;
      end
    endcase
  end

  // a reset command wipes the table and the sample history just like rst
  always_ff @(posedge clk) begin
    if (rst || clr_all) begin
      command   <= '0;
      num_units <= '0;
      poll_idx  <= '0;
      for (int i = 0; i < `SAMPLER_MAX_UNITS; i++) begin
        unit_table[i] <= `SAMPLER_NO_UNIT;
        last_value[i] <= '0;
      end
    end else begin
      // a fresh command write wins over the clear from the state machine
      if (bus_wr && cmd.addr[7:0] == `SAMPLER_ADDR_COMMAND) begin
        command <= cmd.data;
      end else if (clr_cmd) begin
        command <= '0;
      end
      // registrations beyond the table size are ignored
      if (new_unit_wr && !table_full) begin
        unit_table[num_units[IDX_W-1:0]] <= cmd.data[7:0];
      end
      if (new_unit_done && !table_full) begin
        num_units <= num_units + CNT_W'(1);
      end
      if (fifo_wr) begin
        last_value[poll_idx] <= sample_data;
      end
      if (inc_idx) begin
        poll_idx <= (poll_idx == last_idx) ? '0 : poll_idx + IDX_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
//==============================
// sample FIFO
// synchronous first-word-fall-through buffer with
// level flags and an occupancy count
//==============================
`default_nettype none
`include "sampler_consts.svh"

module sample_fifo (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear,
  input  logic                      wr,
  input  sampler_pkg::sample_word_t din,
  input  logic                      rd,
  output sampler_pkg::sample_word_t dout,
  output sampler_pkg::fifo_status_t status
);

  import sampler_pkg::*;

  localparam int DEPTH = `SAMPLER_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  localparam logic [AW-1:0] LAST_SLOT   = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_LEVEL  = CW'(DEPTH);
  localparam logic [CW-1:0] ALMOST_FULL = CW'(DEPTH - 1);

  sample_word_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] level;
  logic          is_empty;
  logic          is_full;
  logic          do_wr;
  logic          do_rd;

  // pointer advance with an explicit wrap so any depth works
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + AW'(1);
  endfunction

  assign is_empty = (level == '0);
  assign is_full  = (level == FULL_LEVEL);

  // writes into a full buffer and reads from an empty one are dropped
  assign do_wr = wr & ~is_full;
  assign do_rd = rd & ~is_empty;

  // head of the queue is always on the output
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // clear empties the buffer in one cycle without touching the storage
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10: level <= level + CW'(1);
        2'b01: level <= level - CW'(1);
        default: level <= level;
      endcase
    end
  end

  // flags follow the registered level, so a write shows one cycle later
  always_comb begin
    status.empty        = is_empty;
    status.almost_empty = (level <= CW'(1));
    status.full         = is_full;
    status.almost_full  = (level >= ALMOST_FULL);
    status.count        = 16'(level);
  end

endmodule

`default_nettype wire

// ==== sampler_consts.svh ====
//==============================
// sampler constants
// bus position, register offsets, command codes and sizes
// shared by the collector, the FIFO and the testbench
//==============================
`ifndef SAMPLER_CONSTS_SVH
`define SAMPLER_CONSTS_SVH

// high address byte that selects the collector on the command bus
`define SAMPLER_POSITION 8'd242

// low address byte offsets inside the collector
// a write to new unit appends the data byte to the unit table
`define SAMPLER_ADDR_NEW_UNIT 8'd4
`define SAMPLER_ADDR_COMMAND 8'd5

// command codes written to the command register
`define SAMPLER_CMD_START 32'd1
`define SAMPLER_CMD_STOP 32'd2
`define SAMPLER_CMD_RES_FIFO 32'd3
`define SAMPLER_CMD_RESET 32'd5

// number of entries in the unit table
`define SAMPLER_MAX_UNITS 8

// table filler, a position that no capture unit answers to
`define SAMPLER_NO_UNIT 8'd255

// number of entries in the sample FIFO
`define SAMPLER_FIFO_DEPTH 16

`endif

// ==== sampler_pkg.sv ====
//==============================
// sampler types
// packed structs for the command bus, the FIFO entry
// and the FIFO status flags
//==============================
`default_nettype none

package sampler_pkg;

  // one command bus transfer, a write happens when cs and wr are both high
  // the high address byte selects the block, the low byte the register
  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] data;
    logic        cs;
    logic        wr;
  } cmd_bus_t;

  // one FIFO entry, the table index of the unit and the low sample bits
  typedef struct packed {
    logic [2:0]  unit_idx;
    logic [12:0] value;
  } sample_word_t;

  // level flags of the sample FIFO together with its occupancy
  // almost_empty is set at a count of one or less
  // almost_full is set at a count of depth minus one or more
  typedef struct packed {
    logic        empty;
    logic        almost_empty;
    logic        full;
    logic        almost_full;
    logic [15:0] count;
  } fifo_status_t;

endpackage

`default_nettype wire

// ==== sampler_top.sv ====
//==============================
// sampler top
// collector, sample FIFO and two capture units
// on a shared command bus and sample bus
//==============================
`default_nettype none

module sampler_top (
  input  logic                      clk,
  input  logic                      rst,
  input  sampler_pkg::cmd_bus_t     cmd,
  input  logic [15:0]               raw_a,
  input  logic [15:0]               raw_b,
  input  logic                      sample_rd,
  output sampler_pkg::sample_word_t sample_out,
  output sampler_pkg::fifo_status_t status,
  output logic                      output_sample,
  output logic [7:0]                channel_select
);

  import sampler_pkg::*;

  sample_word_t fifo_din;
  logic         fifo_wr;
  logic         fifo_clear;
  logic [31:0]  sample_data_a;
  logic [31:0]  sample_data_b;
  logic [31:0]  sample_data;

  // only the polled unit drives a non-zero word
  assign sample_data = sample_data_a | sample_data_b;

  sample_collector i_collector (
    .clk            (clk),
    .rst            (rst),
    .cmd            (cmd),
    .sample_data    (sample_data),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .fifo_wr        (fifo_wr),
    .fifo_din       (fifo_din),
    .fifo_clear     (fifo_clear)
  );

  sample_fifo i_fifo (
    .clk    (clk),
    .rst    (rst),
    .clear  (fifo_clear),
    .wr     (fifo_wr),
    .din    (fifo_din),
    .rd     (sample_rd),
    .dout   (sample_out),
    .status (status)
  );

  // two converter channels at their own bus positions
  capture_unit #(.UNIT_POSITION(8'd17)) i_unit_a (
    .clk            (clk),
    .rst            (rst),
    .raw            (raw_a),
    .channel_select (channel_select),
    .output_sample  (output_sample),
    .sample_data    (sample_data_a)
  );

  capture_unit #(.UNIT_POSITION(8'd34)) i_unit_b (
    .clk            (clk),
    .rst            (rst),
    .raw            (raw_b),
    .channel_select (channel_select),
    .output_sample  (output_sample),
    .sample_data    (sample_data_b)
  );

endmodule

`default_nettype wire

// ==== tb_sampler_top.sv ====
//==============================
// sampler testbench
// registers two capture units, polls them and checks
// the FIFO contents against a queue model
//==============================
`default_nettype none
`include "sampler_consts.svh"

module tb_sampler_top;

  import sampler_pkg::*;

  // two units at four cycles per poll
  localparam int POLL_ROUND     = 8;
  localparam int WAIT_LIMIT     = 3 * POLL_ROUND;
  localparam int SETTLE_CYCLES  = WAIT_LIMIT + 2 * POLL_ROUND + 4;
  // about twenty settle windows plus bus writes, stops and FIFO reads
  localparam int TEST_CYCLES    = 20 * SETTLE_CYCLES + 300;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic         clk;
  logic         rst;
  cmd_bus_t     cmd;
  logic [15:0]  raw_a;
  logic [15:0]  raw_b;
  logic         sample_rd;
  sample_word_t sample_out;
  fifo_status_t status;
  logic         output_sample;
  logic [7:0]   channel_select;

  // expected FIFO contents and the last value each unit reported
  sample_word_t exp_q [$];
  logic [15:0]  last_raw [2];
  logic [15:0]  model_count;
  logic         synced;
  int           seed;
  int           value_errors;
  int           event_errors;
  int           cycles;

  // flag levels that follow from the model count
  logic exp_empty;
  logic exp_almost_empty;
  logic exp_full;
  logic exp_almost_full;

  sampler_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .cmd            (cmd),
    .raw_a          (raw_a),
    .raw_b          (raw_b),
    .sample_rd      (sample_rd),
    .sample_out     (sample_out),
    .status         (status),
    .output_sample  (output_sample),
    .channel_select (channel_select)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing the tests", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    value_errors = value_errors + 1;
  endtask

  task automatic report_failure(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    event_errors = event_errors + 1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else report_value(name, got, exp);
  endtask

  assign exp_empty        = (model_count == 16'd0);
  assign exp_almost_empty = (model_count <= 16'd1);
  assign exp_full         = (model_count == 16'(`SAMPLER_FIFO_DEPTH));
  assign exp_almost_full  = (model_count >= 16'(`SAMPLER_FIFO_DEPTH - 1));

  // flags are held against the model while the FIFO level is settled
  assert property (@(posedge clk) disable iff (rst || !synced)
                   status.empty == exp_empty)
    else report_value("status.empty", 32'($sampled(status.empty)), 32'($sampled(exp_empty)));
  assert property (@(posedge clk) disable iff (rst || !synced)
                   status.almost_empty == exp_almost_empty)
    else report_value("status.almost_empty", 32'($sampled(status.almost_empty)),
                      32'($sampled(exp_almost_empty)));
  assert property (@(posedge clk) disable iff (rst || !synced)
                   status.full == exp_full)
    else report_value("status.full", 32'($sampled(status.full)), 32'($sampled(exp_full)));
  assert property (@(posedge clk) disable iff (rst || !synced)
                   status.almost_full == exp_almost_full)
    else report_value("status.almost_full", 32'($sampled(status.almost_full)),
                      32'($sampled(exp_almost_full)));
  // once the model has caught up, the count must not move
  assert property (@(posedge clk) disable iff (rst || !synced) status.count == model_count)
    else report_value("status.count", 32'($sampled(status.count)), 32'($sampled(model_count)));

  // one write cycle on the command bus addressed to the collector
  task automatic bus_write(input logic [7:0] offset, input logic [31:0] data);
    @(negedge clk);
    cmd.addr = {`SAMPLER_POSITION, offset};
    cmd.data = data;
    cmd.cs   = 1'b1;
    cmd.wr   = 1'b1;
    @(negedge clk);
    cmd = '0;
  endtask

  // the unit count moves two cycles after the write, so leave three idle
  task automatic register_unit(input logic [7:0] position);
    bus_write(`SAMPLER_ADDR_NEW_UNIT, {24'd0, position});
    repeat (3) @(negedge clk);
  endtask

  task automatic send_command(input logic [31:0] code);
    bus_write(`SAMPLER_ADDR_COMMAND, code);
  endtask

  // a new random raw value that is sure to differ from the old one
  function automatic logic [15:0] pick_raw(input logic [15:0] old);
    logic [15:0] v;
    v = 16'($random(seed));
    if (v == old) begin
      v = ~old;
    end
    return v;
  endfunction

  // a changed input gives one entry tagged with the unit's table index
  // unless the FIFO is already full, in which case the sample is lost
  task automatic apply_raw(input int unit, input logic [15:0] value);
    sample_word_t w;
    @(negedge clk);
    if (unit == 0) begin
      raw_a = value;
    end else begin
      raw_b = value;
    end
    if (value != last_raw[unit]) begin
      last_raw[unit] = value;
      if (exp_q.size() < `SAMPLER_FIFO_DEPTH) begin
        w.unit_idx = 3'(unit);
        w.value    = value[12:0];
        exp_q.push_back(w);
      end
    end
  endtask

  task automatic wait_until_count(input int target);
    int waited;
    waited = 0;
    while (int'(status.count) != target && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    check_value("status.count", 32'(status.count), 32'(target));
  endtask

  // wait for the model count, then watch two rounds with no new entries
  task automatic settle_fifo();
    wait_until_count(exp_q.size());
    model_count = 16'(exp_q.size());
    synced = 1'b1;
    repeat (2 * POLL_ROUND) @(negedge clk);
    synced = 1'b0;
  endtask

  // polling never leaves the strobe low for three cycles in a row
  task automatic wait_for_idle();
    int low_run;
    int waited;
    low_run = 0;
    waited  = 0;
    while (low_run < 3 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited  = waited + 1;
      low_run = output_sample ? 0 : low_run + 1;
    end
    if (low_run < 3) begin
      report_failure("polling did not stop after the stop command");
    end
  endtask

  // while stopped the count stays at the last settled model level
  task automatic hold_stopped(input int length);
    repeat (length) begin
      @(negedge clk);
      assert (!output_sample) else report_failure("sample strobe rose while stopped");
      check_value("status.count", 32'(status.count), 32'(model_count));
    end
  endtask

  // the head is on sample_out before the read, the pop lands on the edge
  task automatic pop_and_compare();
    sample_word_t head;
    head = exp_q.pop_front();
    @(negedge clk);
    assert (!status.empty) else report_failure("FIFO empty while entries are still expected");
    assert (sample_out == head) else report_value("sample_out", 32'(sample_out), 32'(head));
    sample_rd = 1'b1;
    @(negedge clk);
    sample_rd = 1'b0;
  endtask

  initial begin
    int extra;
    clk          = 1'b0;
    rst          = 1'b1;
    cmd          = '0;
    raw_a        = '0;
    raw_b        = '0;
    sample_rd    = 1'b0;
    seed         = 32'h9d40_f958;
    value_errors = 0;
    event_errors = 0;
    cycles       = 0;
    synced       = 1'b0;
    model_count  = '0;
    last_raw[0]  = '0;
    last_raw[1]  = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // after reset the FIFO is empty and the table holds only fillers
    @(negedge clk);
    check_value("status.empty", 32'(status.empty), 32'd1);
    check_value("status.almost_empty", 32'(status.almost_empty), 32'd1);
    check_value("status.count", 32'(status.count), 32'd0);
    check_value("output_sample", 32'(output_sample), 32'd0);
    check_value("channel_select", 32'(channel_select), 32'(`SAMPLER_NO_UNIT));

    // unit 17 lands at index 0 and unit 34 at index 1
    register_unit(8'd17);
    register_unit(8'd34);
    apply_raw(0, pick_raw(last_raw[0]));
    apply_raw(1, pick_raw(last_raw[1]));
    send_command(`SAMPLER_CMD_START);
    settle_fifo();
    check_value("sample_out", 32'(sample_out), 32'(exp_q[0]));

    // only unit b moves, so only index 1 reports
    apply_raw(1, pick_raw(last_raw[1]));
    settle_fifo();

    // stop, change an input while idle, then resume
    send_command(`SAMPLER_CMD_STOP);
    wait_for_idle();
    hold_stopped(2 * POLL_ROUND);
    apply_raw(0, pick_raw(last_raw[0]));
    hold_stopped(POLL_ROUND);
    send_command(`SAMPLER_CMD_START);
    settle_fifo();

    // run past the depth, the last two samples are dropped
    extra = `SAMPLER_FIFO_DEPTH - exp_q.size() + 2;
    for (int i = 0; i < extra; i++) begin
      apply_raw(i % 2, pick_raw(last_raw[i % 2]));
      settle_fifo();
    end
    check_value("status.full", 32'(status.full), 32'd1);
    check_value("status.almost_full", 32'(status.almost_full), 32'd1);
    check_value("status.count", 32'(status.count), 32'(`SAMPLER_FIFO_DEPTH));
    send_command(`SAMPLER_CMD_STOP);
    wait_for_idle();
    while (exp_q.size() > 0) begin
      pop_and_compare();
    end
    @(negedge clk);
    check_value("status.empty", 32'(status.empty), 32'd1);

    // put one entry in, then flush it with the FIFO clear command
    send_command(`SAMPLER_CMD_START);
    apply_raw(1, pick_raw(last_raw[1]));
    settle_fifo();
    send_command(`SAMPLER_CMD_STOP);
    wait_for_idle();
    send_command(`SAMPLER_CMD_RES_FIFO);
    exp_q.delete();
    wait_until_count(0);

    // the table survived the flush, so unit 17 still reports at index 0
    apply_raw(0, pick_raw(last_raw[0]));
    send_command(`SAMPLER_CMD_START);
    settle_fifo();
    check_value("sample_out", 32'(sample_out), 32'(exp_q[0]));
    send_command(`SAMPLER_CMD_STOP);
    wait_for_idle();

    // full reset wipes the table, the history and the FIFO
    send_command(`SAMPLER_CMD_RESET);
    exp_q.delete();
    last_raw[0] = '0;
    last_raw[1] = '0;
    repeat (3) @(negedge clk);
    check_value("channel_select", 32'(channel_select), 32'(`SAMPLER_NO_UNIT));
    check_value("status.empty", 32'(status.empty), 32'd1);
    check_value("status.count", 32'(status.count), 32'd0);
    check_value("output_sample", 32'(output_sample), 32'd0);

    $display("errors: %0d wrong values, %0d other failures", value_errors, event_errors);
    if (value_errors == 0 && event_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
